//--- hw/softmax_pkg.sv
// Shared widths, opcodes, FSM states and bus structs for the softmax engine
// Base-2 fixed point with 16 fraction bits, so a result of 65536 means 1.0
// SUM_WIDTH covers up to 64 columns of e = 65536 each
// Sizes travel as DIM_WIDTH counts from 1 to 64

package softmax_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Input element, two's complement
  localparam int ELEM_WIDTH = 8;
  localparam int FRAC_BITS  = 16;
  // Result holds 0 to 65536
  localparam int RES_WIDTH  = 17;
  localparam int SUM_WIDTH  = 23;
  localparam int DIM_WIDTH  = 7;
  // Divider input, e shifted left by FRAC_BITS
  localparam int DIVD_WIDTH = RES_WIDTH + FRAC_BITS;

  // Exponential of a zero spread
  localparam logic [RES_WIDTH-1:0] EXP_ONE = RES_WIDTH'(1) << FRAC_BITS;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_SET_ROWS = 2'd0,
    OP_SET_COLS = 2'd1,
    OP_START    = 2'd2
  } sm_op_t;

  typedef enum logic [1:0] {VS_IDLE, VS_LOAD, VS_EXP, VS_NORM} vec_state_t;

  typedef enum logic [1:0] {MS_IDLE, MS_ROW, MS_WAIT} mat_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Buses
  ////////////////////////////////////////////////////////////////////////////

  // Configuration command, 10 bits
  typedef struct packed {
    sm_op_t     op;
    logic [7:0] value;
  } sm_cfg_cmd_t;

  // One result with its position flags, 19 bits
  typedef struct packed {
    logic [RES_WIDTH-1:0] value;
    logic                 col_last;
    logic                 row_last;
  } sm_result_t;

endpackage

//--- hw/softmax_cfg_regs.sv
// Four-phase req/ack configuration block
// Host holds cfg_cmd stable from cfg_req rise until cfg_ack rises
// Host must wait for cfg_ack low before the next cfg_req
// Out-of-range sizes and OP_START while busy are acknowledged and dropped
// Sizes come out of reset as 1 x 1

`timescale 1ns/10ps

module softmax_cfg_regs #(
  parameter int MAX_ROWS = 16,
  parameter int MAX_COLS = 16
) (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              cfg_req,
  input  softmax_pkg::sm_cfg_cmd_t          cfg_cmd,
  output logic                              cfg_ack,
  input  logic                              busy,
  output logic                              start,
  output logic [softmax_pkg::DIM_WIDTH-1:0] rows,
  output logic [softmax_pkg::DIM_WIDTH-1:0] cols
);

  import softmax_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  logic req_rise;
  logic rows_ok;
  logic cols_ok;

  // Ack is req delayed by one cycle, so it also serves as the edge detector
  assign req_rise = cfg_req && !cfg_ack;

  // Range checks, zero is never legal
  assign rows_ok = (cfg_cmd.value != 8'd0) && (cfg_cmd.value <= MAX_ROWS);
  assign cols_ok = (cfg_cmd.value != 8'd0) && (cfg_cmd.value <= MAX_COLS);

  ////////////////////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cfg_ack <= 1'b0;
      start   <= 1'b0;
      rows    <= DIM_WIDTH'(1);
      cols    <= DIM_WIDTH'(1);
    end else begin
      // Follows req one cycle late in both directions
      cfg_ack <= cfg_req;
      // Start is a single-cycle pulse
      start   <= 1'b0;

      // Act once per request, on its first sampled cycle
      if (req_rise) begin
        case (cfg_cmd.op)
          OP_SET_ROWS: begin
            if (rows_ok) begin
              rows <= cfg_cmd.value[DIM_WIDTH-1:0];
            end
          end
          OP_SET_COLS: begin
            if (cols_ok) begin
              cols <= cfg_cmd.value[DIM_WIDTH-1:0];
            end
          end
          OP_START: begin
            // A run in progress is never restarted
            start <= !busy;
          end
          default: begin
            // Unknown opcode, ack only
          end
        endcase
      end
    end
  end

endmodule

//--- hw/softmax_divider.sv
// Restoring divider for one normalized softmax output
// Requires dividend < divisor << RES_WIDTH, true when e <= row sum
// done pulses 18 cycles after start, quotient holds until the next start
// A start during a divide restarts it

`timescale 1ns/10ps

module softmax_divider (
  input  logic                               CLK,
  input  logic                               RST,
  input  logic                               start,
  input  logic [softmax_pkg::DIVD_WIDTH-1:0] dividend,
  input  logic [softmax_pkg::SUM_WIDTH-1:0]  divisor,
  output logic [softmax_pkg::RES_WIDTH-1:0]  quotient,
  output logic                               done
);

  import softmax_pkg::*;

  logic                 running;
  logic [4:0]           bit_cnt;
  logic [SUM_WIDTH-1:0] divisor_q;
  // Partial remainder, always below the divisor
  logic [SUM_WIDTH-1:0] rem;
  // Low dividend bits shift out the top, quotient bits shift in below
  logic [RES_WIDTH-1:0] shreg;
  logic [SUM_WIDTH:0]   trial;
  logic                 q_bit;

  assign trial    = {rem, shreg[RES_WIDTH-1]};
  assign q_bit    = (trial >= {1'b0, divisor_q});
  assign quotient = shreg;

  // Control, one quotient bit per cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running <= 1'b0;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        bit_cnt <= 5'(RES_WIDTH - 1);
      end else if (running) begin
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == 5'd0) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  // Datapath, upper dividend bits preload the remainder
  always_ff @(posedge CLK) begin
    if (start) begin
      divisor_q <= divisor;
      rem       <= SUM_WIDTH'(dividend >> RES_WIDTH);
      shreg     <= dividend[RES_WIDTH-1:0];
    end else if (running) begin
      rem   <= q_bit ? SUM_WIDTH'(trial - {1'b0, divisor_q}) : trial[SUM_WIDTH-1:0];
      shreg <= {shreg[RES_WIDTH-2:0], q_bit};
    end
  end

endmodule

//--- hw/vector_softmax.sv
// Single-row base-2 softmax
// cols must stay stable and within 1 to MAX_COLS from row_start to out_last
// Only one row in flight, row_start is ignored unless idle
// Phases are load (max tracking), exp (sum) and norm (one divide each)
// Each result follows its divide by one cycle, out_last on the last column

`timescale 1ns/10ps

module vector_softmax #(
  parameter int MAX_COLS = 16
) (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                row_start,
  input  logic [softmax_pkg::DIM_WIDTH-1:0]   cols,
  input  logic                                elem_enable,
  input  logic signed [softmax_pkg::ELEM_WIDTH-1:0] elem,
  output logic                                elem_ready,
  output logic                                out_enable,
  output logic [softmax_pkg::RES_WIDTH-1:0]   out_value,
  output logic                                out_last
);

  import softmax_pkg::*;

  localparam int ADDR_W = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  vec_state_t                   state;
  logic [DIM_WIDTH-1:0]         idx;
  logic [ADDR_W-1:0]            addr;
  logic                         col_end;

  // Holds raw elements during load, exponentials afterwards
  logic [RES_WIDTH-1:0]         row_buf [MAX_COLS];
  logic signed [ELEM_WIDTH-1:0] row_max;
  logic signed [ELEM_WIDTH-1:0] stored;
  logic [ELEM_WIDTH:0]          spread;
  logic [RES_WIDTH-1:0]         exp_val;
  logic [SUM_WIDTH-1:0]         row_sum;

  // Divider
  logic                         div_start;
  logic                         div_busy;
  logic                         div_done;
  logic [DIVD_WIDTH-1:0]        dividend;
  logic [RES_WIDTH-1:0]         quotient;

  assign addr       = idx[ADDR_W-1:0];
  assign col_end    = (idx == cols - 1'b1);
  assign elem_ready = (state == VS_LOAD);

  // Spread m - x, never negative once the max is known
  assign stored  = row_buf[addr][ELEM_WIDTH-1:0];
  assign spread  = {row_max[ELEM_WIDTH-1], row_max} - {stored[ELEM_WIDTH-1], stored};
  // Shift saturates to zero past FRAC_BITS
  assign exp_val = (spread > FRAC_BITS) ? '0 : EXP_ONE >> spread;

  assign dividend = DIVD_WIDTH'(row_buf[addr]) << FRAC_BITS;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= VS_IDLE;
      idx        <= '0;
      div_start  <= 1'b0;
      div_busy   <= 1'b0;
      out_enable <= 1'b0;
    end else begin
      div_start  <= 1'b0;
      out_enable <= 1'b0;
      case (state)
        VS_IDLE: begin
          if (row_start) begin
            idx   <= '0;
            state <= VS_LOAD;
          end
        end
        VS_LOAD: begin
          if (elem_enable) begin
            idx   <= col_end ? '0 : idx + 1'b1;
            state <= col_end ? VS_EXP : VS_LOAD;
          end
        end
        VS_EXP: begin
          // One entry per cycle
          idx   <= col_end ? '0 : idx + 1'b1;
          state <= col_end ? VS_NORM : VS_EXP;
        end
        VS_NORM: begin
          if (!div_busy) begin
            div_start <= 1'b1;
            div_busy  <= 1'b1;
          end else if (div_done) begin
            div_busy   <= 1'b0;
            out_enable <= 1'b1;
            idx        <= col_end ? '0 : idx + 1'b1;
            state      <= col_end ? VS_IDLE : VS_NORM;
          end
        end
        default: state <= VS_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Row datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      VS_IDLE: begin
        if (row_start) begin
          row_max <= {1'b1, {(ELEM_WIDTH-1){1'b0}}};
          row_sum <= '0;
        end
      end
      VS_LOAD: begin
        if (elem_enable) begin
          row_buf[addr] <= {{(RES_WIDTH-ELEM_WIDTH){1'b0}}, elem};
          // Running max, includes the last element on the way out
          if (elem > row_max) begin
            row_max <= elem;
          end
        end
      end
      VS_EXP: begin
        // Exponential replaces the raw element in place
        row_buf[addr] <= exp_val;
        row_sum       <= row_sum + SUM_WIDTH'(exp_val);
      end
      VS_NORM: begin
        if (div_busy && div_done) begin
          out_value <= quotient;
          out_last  <= col_end;
        end
      end
      default: begin
      end
    endcase
  end

  softmax_divider i_divider (
    .CLK     (CLK),
    .RST     (RST),
    .start   (div_start),
    .dividend(dividend),
    .divisor (row_sum),
    .quotient(quotient),
    .done    (div_done)
  );

endmodule

//--- hw/matrix_softmax.sv
// Row sequencer for the matrix softmax
// rows and cols are sampled on start and held for the whole run
// Each row is issued only after the previous row's last result
// No back-pressure, res is valid only with res_enable
// busy stays high through the result that carries row_last

`timescale 1ns/10ps

module matrix_softmax #(
  parameter int MAX_ROWS = 16,
  parameter int MAX_COLS = 16
) (
  input  logic                                      CLK,
  input  logic                                      RST,
  input  logic                                      start,
  input  logic [softmax_pkg::DIM_WIDTH-1:0]         rows,
  input  logic [softmax_pkg::DIM_WIDTH-1:0]         cols,
  input  logic                                      in_enable,
  input  logic signed [softmax_pkg::ELEM_WIDTH-1:0] in_data,
  output logic                                      in_ready,
  output logic                                      res_enable,
  output softmax_pkg::sm_result_t                   res,
  output logic                                      busy
);

  import softmax_pkg::*;

  localparam int ROW_W = (MAX_ROWS > 1) ? $clog2(MAX_ROWS) : 1;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  mat_state_t           state;
  logic [DIM_WIDTH-1:0] rows_q;
  logic [DIM_WIDTH-1:0] cols_q;
  logic [ROW_W-1:0]     row_idx;
  logic                 last_row;
  logic                 row_done;

  // Row engine
  logic                 row_start;
  logic                 elem_ready;
  logic                 out_enable;
  logic [RES_WIDTH-1:0] out_value;
  logic                 out_last;

  assign last_row = (DIM_WIDTH'(row_idx) == rows_q - 1'b1);
  assign row_done = out_enable && out_last;

  // Element stream only while a row is being collected
  assign in_ready = elem_ready && (state == MS_WAIT);

  // Results pass straight through, tagged with position
  assign res_enable = out_enable;
  assign res = '{value: out_value, col_last: out_last, row_last: out_last && last_row};

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= MS_IDLE;
      busy      <= 1'b0;
      row_start <= 1'b0;
      row_idx   <= '0;
    end else begin
      row_start <= 1'b0;
      case (state)
        MS_IDLE: begin
          if (start) begin
            busy    <= 1'b1;
            row_idx <= '0;
            state   <= MS_ROW;
          end
        end
        MS_ROW: begin
          // Kick one row
          row_start <= 1'b1;
          state     <= MS_WAIT;
        end
        MS_WAIT: begin
          if (row_done) begin
            if (last_row) begin
              busy  <= 1'b0;
              state <= MS_IDLE;
            end else begin
              row_idx <= row_idx + 1'b1;
              state   <= MS_ROW;
            end
          end
        end
        default: state <= MS_IDLE;
      endcase
    end
  end

  // Size snapshot for the run
  always_ff @(posedge CLK) begin
    if (state == MS_IDLE && start) begin
      rows_q <= rows;
      cols_q <= cols;
    end
  end

  vector_softmax #(
    .MAX_COLS(MAX_COLS)
  ) i_vector_softmax (
    .CLK        (CLK),
    .RST        (RST),
    .row_start  (row_start),
    .cols       (cols_q),
    .elem_enable(in_enable && in_ready),
    .elem       (in_data),
    .elem_ready (elem_ready),
    .out_enable (out_enable),
    .out_value  (out_value),
    .out_last   (out_last)
  );

endmodule

//--- hw/softmax_top.sv
// Matrix softmax engine top level
// Configure sizes and start over the four-phase cfg port, then stream
// rows x cols signed elements while in_ready is high
// One result per element in input order, with no stall on the output
// MAX_COLS sets the row buffer depth, legal up to 64

`timescale 1ns/10ps

module softmax_top #(
  parameter int MAX_ROWS = 16,
  parameter int MAX_COLS = 16
) (
  input  logic                                      CLK,
  input  logic                                      RST,
  // Configuration port
  input  logic                                      cfg_req,
  input  softmax_pkg::sm_cfg_cmd_t                  cfg_cmd,
  output logic                                      cfg_ack,
  // Element stream
  input  logic                                      in_enable,
  input  logic signed [softmax_pkg::ELEM_WIDTH-1:0] in_data,
  output logic                                      in_ready,
  // Result stream
  output logic                                      res_enable,
  output softmax_pkg::sm_result_t                   res,
  output logic                                      busy
);

  import softmax_pkg::*;

  // Config to sequencer
  logic                 start;
  logic [DIM_WIDTH-1:0] rows;
  logic [DIM_WIDTH-1:0] cols;

  softmax_cfg_regs #(
    .MAX_ROWS(MAX_ROWS),
    .MAX_COLS(MAX_COLS)
  ) i_cfg_regs (
    .CLK    (CLK),
    .RST    (RST),
    .cfg_req(cfg_req),
    .cfg_cmd(cfg_cmd),
    .cfg_ack(cfg_ack),
    .busy   (busy),
    .start  (start),
    .rows   (rows),
    .cols   (cols)
  );

  matrix_softmax #(
    .MAX_ROWS(MAX_ROWS),
    .MAX_COLS(MAX_COLS)
  ) i_matrix_softmax (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .rows      (rows),
    .cols      (cols),
    .in_enable (in_enable),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .res_enable(res_enable),
    .res       (res),
    .busy      (busy)
  );

endmodule

//--- test/softmax_assertions.sv
// Protocol checks for the softmax engine, bound into softmax_top
// Sampled on the rising clock edge, idle while reset is high

`timescale 1ns/10ps

module softmax_assertions (
  input logic CLK,
  input logic RST,
  input logic cfg_req,
  input logic cfg_ack,
  input logic res_enable,
  input logic busy,
  input logic in_ready
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Ack only answers a pending request
  ack_follows_req: assert property (@(posedge CLK) disable iff (RST)
    $rose(cfg_ack) |-> cfg_req)
    else begin
      fail_count++;
      $error("cfg_ack rose while cfg_req was low");
    end

  // Results only inside a run
  res_inside_run: assert property (@(posedge CLK) disable iff (RST)
    res_enable |-> busy)
    else begin
      fail_count++;
      $error("res_enable pulsed while busy was low");
    end

  // No element intake while idle
  ready_inside_run: assert property (@(posedge CLK) disable iff (RST)
    !busy |-> !in_ready)
    else begin
      fail_count++;
      $error("in_ready high while busy was low");
    end

endmodule

bind softmax_top softmax_assertions i_softmax_assertions (
  .CLK       (CLK),
  .RST       (RST),
  .cfg_req   (cfg_req),
  .cfg_ack   (cfg_ack),
  .res_enable(res_enable),
  .busy      (busy),
  .in_ready  (in_ready)
);

//--- test/softmax_tb.sv
// Testbench for softmax_top with default MAX_ROWS and MAX_COLS of 16
// Inputs change on the rising edge, outputs are sampled on the falling edge
// Expected results come from a base-2 softmax model of each sent row
// Random sizes stay within 8 x 16

`timescale 1ns/10ps

module softmax_tb;

  import softmax_pkg::*;

  localparam int MAX_ROWS    = 16;
  localparam int MAX_COLS    = 16;
  localparam int N_RANDOM    = 6;
  // 1x1, 3x4, random, spread 2x16, busy restart 2x8
  localparam int TOTAL_ELEMS = 1 + 12 + N_RANDOM * 8 * 16 + 32 + 16;
  localparam int CYCLE_LIMIT = TOTAL_ELEMS * 30 + 2000;

  logic                         CLK;
  logic                         RST;
  logic                         cfg_req;
  sm_cfg_cmd_t                  cfg_cmd;
  logic                         cfg_ack;
  logic                         in_enable;
  logic signed [ELEM_WIDTH-1:0] in_data;
  logic                         in_ready;
  logic                         res_enable;
  sm_result_t                   res;
  logic                         busy;

  sm_result_t  exp_q[$];
  logic [15:0] lfsr_state;
  int          model_rows;
  int          model_cols;
  int          errors;
  int          checks;
  int          res_count;
  int          cycle_count;
  logic        busy_check;

  softmax_top i_softmax_top (
    .CLK(CLK), .RST(RST), .cfg_req(cfg_req), .cfg_cmd(cfg_cmd), .cfg_ack(cfg_ack),
    .in_enable(in_enable), .in_data(in_data), .in_ready(in_ready),
    .res_enable(res_enable), .res(res), .busy(busy)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int value);
    int i;
    value = 0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | lfsr_state[0];
    end
  endtask

  // Base-2 exponential with 16 fraction bits, zero past a spread of 16
  function automatic longint exp2_fixed(input int d);
    return (d > 16) ? 0 : (longint'(65536) >> d);
  endfunction

  // Normalized output for element k of a row
  function automatic int softmax_ref(input int row_q[$], input int k);
    int     m;
    longint sum;
    m = row_q[0];
    foreach (row_q[i]) begin
      if (row_q[i] > m) m = row_q[i];
    end
    sum = 0;
    foreach (row_q[i]) sum += exp2_fixed(m - row_q[i]);
    return int'((exp2_fixed(m - row_q[k]) * 65536) / sum);
  endfunction

  // Four-phase write, also tracks which sizes the block should accept
  task automatic cfg_write(input sm_op_t op, input int value);
    @(negedge CLK);
    checks++;
    assert (!cfg_ack) else begin
      errors++;
      $display("cfg_ack still high when a new request began at %0t", $time);
    end
    @(posedge CLK);
    cfg_cmd <= '{op: op, value: value[7:0]};
    cfg_req <= 1'b1;
    do @(negedge CLK); while (!cfg_ack);
    @(posedge CLK);
    cfg_req <= 1'b0;
    do @(negedge CLK); while (cfg_ack);
    if (op == OP_SET_ROWS && value >= 1 && value <= MAX_ROWS) model_rows = value;
    if (op == OP_SET_COLS && value >= 1 && value <= MAX_COLS) model_cols = value;
  endtask

  // Holds one element until the engine is ready, taken on the next edge
  task automatic send_elem(input int value);
    @(posedge CLK);
    in_enable <= 1'b1;
    in_data   <= value[7:0];
    do @(negedge CLK); while (!in_ready);
  endtask

  // Mode 0 random, mode 1 wide spreads
  task automatic send_row(input int r, input int nrows, input int ncols, input int mode);
    int         row_q[$];
    int         k;
    int         x;
    sm_result_t expected;
    for (k = 0; k < ncols; k++) begin
      if (mode == 0) begin
        take_bits(8, x);
        x = (x > 127) ? x - 256 : x;
      end else if (r == 0) begin
        x = 100 - 2 * k;
      end else begin
        x = (k == 0) ? 127 : -128 + k;
      end
      send_elem(x);
      row_q.push_back(x);
    end
    @(posedge CLK);
    in_enable <= 1'b0;
    for (k = 0; k < ncols; k++) begin
      expected.value    = RES_WIDTH'(softmax_ref(row_q, k));
      expected.col_last = (k == ncols - 1);
      expected.row_last = (k == ncols - 1) && (r == nrows - 1);
      exp_q.push_back(expected);
    end
  endtask

  task automatic finish_run(input int base, input int count);
    @(negedge CLK);
    while (busy) @(negedge CLK);
    checks++;
    assert (res_count - base == count && exp_q.size() == 0) else begin
      errors++;
      $display("[FAIL] %0t: run gave %0d results, expected %0d", $time, res_count - base, count);
    end
    // Idle engine takes no elements
    repeat (3) begin
      @(negedge CLK);
      checks++;
      assert (!in_ready && !busy) else begin
        errors++;
        $display("Engine not idle after its last result at %0t", $time);
      end
    end
  endtask

  task automatic run_matrix(input int mode);
    int base;
    int r;
    base = res_count;
    cfg_write(OP_START, 0);
    for (r = 0; r < model_rows; r++) send_row(r, model_rows, model_cols, mode);
    finish_run(base, model_rows * model_cols);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result comparison and run limit
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    sm_result_t expected;
    if (!RST) begin
      // busy drops one edge after the row_last result
      if (busy_check) begin
        checks++;
        assert (!busy) else begin
          errors++;
          $display("busy did not fall with the final result at %0t", $time);
        end
        busy_check = 1'b0;
      end
      if (res_enable) begin
        res_count++;
        checks++;
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("Result with no element pending at %0t", $time);
        end
        if (exp_q.size() > 0) begin
          expected = exp_q.pop_front();
          checks++;
          assert (res == expected) else begin
            errors++;
            $display("[FAIL] %0t: got %0d/%0b/%0b, expected %0d/%0b/%0b", $time,
                     res.value, res.col_last, res.row_last,
                     expected.value, expected.col_last, expected.row_last);
          end
          busy_check = expected.row_last;
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Run stopped: no completion within %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int n;
    int base;
    CLK = 1'b0;
    RST = 1'b1;
    cfg_req = 1'b0;
    cfg_cmd = '0;
    in_enable = 1'b0;
    in_data = '0;
    lfsr_state = 16'd50704;
    model_rows = 1;
    model_cols = 1;
    errors = 0;
    checks = 0;
    res_count = 0;
    cycle_count = 0;
    busy_check = 1'b0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // Reset sizes give a 1x1 run
    run_matrix(0);

    // Bad sizes must leave 3x4 in place
    cfg_write(OP_SET_ROWS, 3);
    cfg_write(OP_SET_COLS, 4);
    cfg_write(OP_SET_ROWS, 0);
    cfg_write(OP_SET_ROWS, MAX_ROWS + 1);
    cfg_write(OP_SET_COLS, 0);
    cfg_write(OP_SET_COLS, 200);
    run_matrix(0);

    for (i = 0; i < N_RANDOM; i++) begin
      take_bits(3, n);
      cfg_write(OP_SET_ROWS, n + 1);
      take_bits(4, n);
      cfg_write(OP_SET_COLS, n + 1);
      run_matrix(0);
    end

    // Spreads past 16 saturate to zero
    cfg_write(OP_SET_ROWS, 2);
    cfg_write(OP_SET_COLS, 16);
    run_matrix(1);

    // Second start lands mid-run and is dropped
    cfg_write(OP_SET_COLS, 8);
    base = res_count;
    cfg_write(OP_START, 0);
    send_row(0, 2, 8, 0);
    cfg_write(OP_START, 0);
    send_row(1, 2, 8, 0);
    finish_run(base, 16);

    // Protocol assertion failures from the bound checker count as errors
    errors += i_softmax_top.i_softmax_assertions.fail_count;

    $display("Results: %0d, checks: %0d, errors: %0d", res_count, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- softmax_engine.f
hw/softmax_pkg.sv
hw/softmax_cfg_regs.sv
hw/softmax_divider.sv
hw/vector_softmax.sv
hw/matrix_softmax.sv
hw/softmax_top.sv
test/softmax_assertions.sv
test/softmax_tb.sv
